/* Bender.yml */
package:
  name: s16_main_bus

sources:
  - hdl/s16_map_pkg.sv
  - hdl/s16_io_pkg.sv
  - hdl/s16_bus_if.sv
  - hdl/s16_addr_decode.sv
  - hdl/s16_io_ctrl.sv
  - hdl/s16_mem_arbiter.sv
  - hdl/s16_main_bus.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_s16_main_bus.sv

/* files.f */
hdl/s16_map_pkg.sv
hdl/s16_io_pkg.sv
hdl/s16_bus_if.sv
hdl/s16_addr_decode.sv
hdl/s16_io_ctrl.sv
hdl/s16_mem_arbiter.sv
hdl/s16_main_bus.sv
sim/tb_clk_gen.sv
sim/tb_s16_main_bus.sv

/* hdl/s16_addr_decode.sv */
// CPU-side address decoder.
// Registers each CPU word cycle, sorts it by region and hands it to the
// memory arbiter or the I/O block. Unmapped cycles and ROM writes end
// with a bus error and open-bus data.
`timescale 1ns/1ps

module s16_addr_decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_req,
    input  logic [s16_map_pkg::cpu_addr_w-1:0] cpu_addr,
    input  logic                              cpu_we,
    input  logic [s16_map_pkg::data_w-1:0]     cpu_wdata,
    output logic                              cpu_done,
    output logic [s16_map_pkg::data_w-1:0]     cpu_rdata,
    output logic                              cpu_berr,
    s16_bus_if.master                         io_bus,
    s16_bus_if.master                         mem_bus
);
    import s16_map_pkg::*;

    region_e               cpu_region, region_q;
    logic                  busy;
    logic [cpu_addr_w:1]   addr_q;   // byte address view with bit n at [n]
    logic                  we_q;
    logic [data_w-1:0]     wdata_q;
    logic [bank_w-1:0]     bank;
    logic                  bad_q;
    logic                  cpu_mem;

    assign cpu_region = map_region(cpu_addr);
    assign cpu_mem    = cpu_region inside {region_rom, region_vram, region_ram};

    // ROM is read only
    assign bad_q = (region_q == region_none) || (region_q == region_rom && we_q);

    always_comb begin
        case (region_q)
            region_vram: bank = bank_vram;
            region_ram:  bank = bank_ram;
            default:     bank = bank_rom;
        endcase
    end

    assign mem_bus.addr  = {{(cpu_addr_w - mem_addr_w){1'b0}}, bank, addr_q[ofs_w:1]};
    assign mem_bus.we    = we_q;
    assign mem_bus.wdata = wdata_q;
    assign io_bus.addr   = addr_q;
    assign io_bus.we     = we_q;
    assign io_bus.wdata  = wdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            region_q    <= region_none;
            io_bus.req  <= 1'b0;
            mem_bus.req <= 1'b0;
            cpu_done    <= 1'b0;
            cpu_berr    <= 1'b0;
        end else begin
            io_bus.req  <= 1'b0;
            mem_bus.req <= 1'b0;
            cpu_done    <= 1'b0;
            cpu_berr    <= 1'b0;
            if (cpu_req) begin
                busy        <= 1'b1;
                region_q    <= cpu_region;
                io_bus.req  <= cpu_region == region_io;
                mem_bus.req <= cpu_mem && !(cpu_region == region_rom && cpu_we);
            end
            if (busy && (bad_q || io_bus.done || mem_bus.done)) begin
                busy     <= 1'b0;
                cpu_done <= 1'b1;
                cpu_berr <= bad_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req) begin
            addr_q  <= cpu_addr;
            we_q    <= cpu_we;
            wdata_q <= cpu_wdata;
        end
        if (busy) begin
            if (bad_q)
                cpu_rdata <= open_bus;
            else if (io_bus.done)
                cpu_rdata <= io_bus.rdata;
            else if (mem_bus.done)
                cpu_rdata <= mem_bus.rdata;
        end
    end

    // the master waits for cpu_done before the next cycle
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        cpu_req |-> !busy);

endmodule

/* hdl/s16_bus_if.sv */
// Single word-cycle bus between the decoder and its two targets.
// req and done are one-cycle strobes; one cycle outstanding at a time.
// addr is CPU wide, memory targets use only the low bits.
`timescale 1ns/1ps

interface s16_bus_if;
    import s16_map_pkg::*;

    logic                  req;
    logic [cpu_addr_w-1:0] addr;
    logic                  we;
    logic [data_w-1:0]     wdata;
    logic [data_w-1:0]     rdata;
    logic                  done;

    modport master (
        output req, addr, we, wdata,
        input  rdata, done
    );

    modport slave (
        input  req, addr, we, wdata,
        output rdata, done
    );
endinterface

/* hdl/s16_io_ctrl.sv */
// Main-board I/O block.
// Serves cabinet inputs reordered per game, DIP switch reads and the
// control register holding the sound latch and the flip bit. Also raises
// the vertical-blank interrupt, cleared by the CPU acknowledge.
`timescale 1ns/1ps

module s16_io_ctrl (
    input  logic        clk,
    input  logic        rst,
    s16_bus_if.slave    io_bus,
    input  logic [1:0]  game_id,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [7:0]  joystick3,
    input  logic [7:0]  joystick4,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana2,
    input  logic [3:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic        vint,
    input  logic        irq_ack,
    output logic [7:0]  snd_latch,
    output logic        flip,
    output logic        irq_n
);
    import s16_map_pkg::*;
    import s16_io_pkg::*;

    logic [cpu_addr_w:1] a;
    game_e               game;
    io_sel_e             sel;
    logic [7:0]          sort1, sort2, cab_byte;
    logic [data_w-1:0]   rd_word;
    logic [1:0]          port_cnt, cnt_nxt; // Passing Shot player select
    logic                last_vint;

    // SDI analog sticks, upper byte negated when the screen is flipped
    function automatic logic [7:0] sdi_ana(input logic [15:0] joyana, input logic flp);
        return flp ? (~joyana[15:8] + 8'd1) : joyana[7:0];
    endfunction

    assign a       = io_bus.addr;
    assign game    = game_e'(game_id);
    assign sel     = io_sel_e'(a[13:12]);
    assign sort1   = sort_joy(joystick1);
    assign sort2   = sort_joy(joystick2);
    assign cnt_nxt = port_cnt + 2'd1;

    always_comb begin
        cab_byte = 8'hff;
        case (a[2:1])
            2'd0: begin // buttons
                cab_byte = {2'b11, start_button[1:0], service, dip_test, coin_input};
                if (game == game_sdi)
                    cab_byte[7:6] = {joystick2[4], joystick1[4]};
                else if (game == game_passsht)
                    cab_byte[7:6] = start_button[3:2];
            end
            2'd1: begin
                case (game)
                    game_sdi: cab_byte = sdi_ana(joyana1, flip);
                    game_passsht: begin
                        case (cnt_nxt) // each read moves to the next player
                            2'd1:    cab_byte = pass_joy(joystick1);
                            2'd2:    cab_byte = pass_joy(joystick2);
                            2'd3:    cab_byte = pass_joy(joystick3);
                            default: cab_byte = pass_joy(joystick4);
                        endcase
                    end
                    default: cab_byte = sort1;
                endcase
            end
            2'd2: begin
                if (game == game_sdi)
                    cab_byte = {sort2[7:4], sort1[7:4]}; // fire nibbles
            end
            default: cab_byte = (game == game_sdi) ? sdi_ana(joyana2, flip) : sort2;
        endcase
    end

    always_comb begin
        case (sel)
            io_ctrl: rd_word = {flip, 7'h7f, snd_latch};
            io_cab:  rd_word = {8'hff, cab_byte};
            io_dip:  rd_word = {8'hff, a[1] ? dipsw_b : dipsw_a};
            default: rd_word = open_bus;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_bus.done <= 1'b0;
            snd_latch   <= 8'd0;
            flip        <= 1'b0;
            port_cnt    <= 2'd0;
            last_vint   <= 1'b0;
            irq_n       <= 1'b1;
        end else begin
            io_bus.done <= io_bus.req; // fixed one-cycle answer
            if (io_bus.req && io_bus.we && sel == io_ctrl) begin
                snd_latch <= io_bus.wdata[7:0];
                flip      <= io_bus.wdata[15];
            end
            if (io_bus.req && !io_bus.we && sel == io_cab) begin
                if (a[2:1] == 2'd0)
                    port_cnt <= 2'd0; // button read restarts the rotation
                else if (a[2:1] == 2'd1 && game == game_passsht)
                    port_cnt <= cnt_nxt;
            end
            last_vint <= vint;
            if (irq_ack)
                irq_n <= 1'b1; // ack wins over a new edge
            else if (vint && !last_vint)
                irq_n <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (io_bus.req)
            io_bus.rdata <= rd_word;
    end

endmodule

/* hdl/s16_io_pkg.sv */
// Cabinet I/O definitions: game identifiers, I/O sub-selects and the
// per-game joystick bit orders used by the I/O block.
package s16_io_pkg;

    typedef enum logic [1:0] {
        game_std     = 2'd0,
        game_sdi     = 2'd1,
        game_passsht = 2'd2
    } game_e;

    // address bits 13..12 inside the I/O window
    typedef enum logic [1:0] {
        io_ctrl = 2'd0,
        io_cab  = 2'd1,
        io_dip  = 2'd2
    } io_sel_e;

    // standard board wiring of a joystick byte
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    // Passing Shot swaps the direction pairs only
    function automatic logic [7:0] pass_joy(input logic [7:0] joy);
        return {joy[7:4], joy[1:0], joy[3:2]};
    endfunction

endpackage

/* hdl/s16_main_bus.sv */
// Main-board bus controller top level.
// A CPU-side master and a debug dump port reach one external memory and
// the cabinet I/O block through the decoder and the memory arbiter.
`timescale 1ns/1ps

module s16_main_bus (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cpu_req,
    input  logic [s16_map_pkg::cpu_addr_w-1:0] cpu_addr,
    input  logic                               cpu_we,
    input  logic [s16_map_pkg::data_w-1:0]     cpu_wdata,
    output logic                               cpu_done,
    output logic [s16_map_pkg::data_w-1:0]     cpu_rdata,
    output logic                               cpu_berr,
    input  logic                               dbg_req,
    input  logic [s16_map_pkg::mem_addr_w-1:0] dbg_addr,
    output logic                               dbg_done,
    output logic [s16_map_pkg::data_w-1:0]     dbg_rdata,
    output logic                               mem_cs,
    output logic [s16_map_pkg::mem_addr_w-1:0] mem_addr,
    output logic                               mem_we,
    output logic [s16_map_pkg::data_w-1:0]     mem_wdata,
    input  logic [s16_map_pkg::data_w-1:0]     mem_rdata,
    input  logic                               mem_ok,
    input  logic [1:0]                         game_id,
    input  logic [7:0]                         joystick1,
    input  logic [7:0]                         joystick2,
    input  logic [7:0]                         joystick3,
    input  logic [7:0]                         joystick4,
    input  logic [15:0]                        joyana1,
    input  logic [15:0]                        joyana2,
    input  logic [3:0]                         start_button,
    input  logic [1:0]                         coin_input,
    input  logic                               service,
    input  logic                               dip_test,
    input  logic [7:0]                         dipsw_a,
    input  logic [7:0]                         dipsw_b,
    input  logic                               vint,
    input  logic                               irq_ack,
    output logic [7:0]                         snd_latch,
    output logic                               flip,
    output logic                               irq_n
);

    s16_bus_if io_bus ();
    s16_bus_if mem_bus ();

    s16_addr_decode u_decode (
        .clk, .rst,
        .cpu_req, .cpu_addr, .cpu_we, .cpu_wdata,
        .cpu_done, .cpu_rdata, .cpu_berr,
        .io_bus  (io_bus),
        .mem_bus (mem_bus)
    );

    s16_io_ctrl u_io (
        .clk, .rst,
        .io_bus (io_bus),
        .game_id, .joystick1, .joystick2, .joystick3, .joystick4,
        .joyana1, .joyana2, .start_button, .coin_input, .service,
        .dip_test, .dipsw_a, .dipsw_b, .vint, .irq_ack,
        .snd_latch, .flip, .irq_n
    );

    s16_mem_arbiter u_arb (
        .clk, .rst,
        .mem_bus (mem_bus),
        .dbg_req, .dbg_addr, .dbg_done, .dbg_rdata,
        .mem_cs, .mem_addr, .mem_we, .mem_wdata,
        .mem_rdata, .mem_ok
    );

endmodule

/* hdl/s16_map_pkg.sv */
// Main-board address map and bus sizes.
// Shared by the address decoder, the memory arbiter and the bus interface.
// CPU addresses are word addresses covering byte address bits 23 to 1.
package s16_map_pkg;

    localparam int cpu_addr_w = 23;
    localparam int data_w     = 16;
    localparam int bank_w     = 2;
    localparam int ofs_w      = 17; // byte address bits 17..1
    localparam int mem_addr_w = bank_w + ofs_w;

    localparam logic [bank_w-1:0] bank_rom  = 2'd0;
    localparam logic [bank_w-1:0] bank_vram = 2'd1;
    localparam logic [bank_w-1:0] bank_ram  = 2'd2;

    localparam logic [data_w-1:0] open_bus = 16'hffff;

    typedef enum logic [2:0] {
        region_rom,
        region_vram,
        region_ram,
        region_io,
        region_none
    } region_e;

    // bit n of the byte address sits at a[n]
    function automatic region_e map_region(input logic [cpu_addr_w:1] a);
        if (a[23:22] == 2'd0 && !a[18])                return region_rom;  // 00-03
        if (a[22] && a[18:16] == 3'd0)                 return region_vram; // 40
        if (a[23:22] == 2'd3 && a[18:16] == 3'd7)      return region_ram;  // c7
        if (a[23:22] == 2'd3 && a[18:17] == 2'd2)      return region_io;   // c4
        return region_none;
    endfunction

endpackage

/* hdl/s16_mem_arbiter.sv */
// Shares the one external memory port between the CPU path and the
// debug dump port. Requests are held as pending flags and granted with
// fixed CPU priority, one access in flight. mem_cs stays high until
// mem_ok and drops for at least a cycle between accesses.
`timescale 1ns/1ps

module s16_mem_arbiter (
    input  logic                               clk,
    input  logic                               rst,
    s16_bus_if.slave                           mem_bus,
    input  logic                               dbg_req,
    input  logic [s16_map_pkg::mem_addr_w-1:0] dbg_addr,
    output logic                               dbg_done,
    output logic [s16_map_pkg::data_w-1:0]     dbg_rdata,
    output logic                               mem_cs,
    output logic [s16_map_pkg::mem_addr_w-1:0] mem_addr,
    output logic                               mem_we,
    output logic [s16_map_pkg::data_w-1:0]     mem_wdata,
    input  logic [s16_map_pkg::data_w-1:0]     mem_rdata,
    input  logic                               mem_ok
);
    import s16_map_pkg::*;

    typedef enum logic [1:0] {own_idle, own_cpu, own_dbg} owner_e;

    owner_e                owner;
    logic                  cpu_pend, dbg_pend;
    logic                  dbg_req_q; // lines the dump strobe up with the decoder stage
    logic [mem_addr_w-1:0] cpu_addr_h, dbg_addr_h;
    logic                  cpu_we_h;
    logic [data_w-1:0]     cpu_wdata_h;

    // held requests stay put while their access is in flight
    assign mem_addr  = (owner == own_dbg) ? dbg_addr_h : cpu_addr_h;
    assign mem_we    = (owner == own_cpu) && cpu_we_h;
    assign mem_wdata = cpu_wdata_h;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner        <= own_idle;
            cpu_pend     <= 1'b0;
            dbg_pend     <= 1'b0;
            dbg_req_q    <= 1'b0;
            mem_cs       <= 1'b0;
            mem_bus.done <= 1'b0;
            dbg_done     <= 1'b0;
        end else begin
            mem_bus.done <= 1'b0;
            dbg_done     <= 1'b0;
            dbg_req_q    <= dbg_req;
            if (mem_bus.req) cpu_pend <= 1'b1;
            if (dbg_req_q)   dbg_pend <= 1'b1;
            if (owner == own_idle) begin
                if (cpu_pend) begin
                    owner    <= own_cpu;
                    cpu_pend <= 1'b0;
                    mem_cs   <= 1'b1;
                end else if (dbg_pend) begin
                    owner    <= own_dbg;
                    dbg_pend <= 1'b0;
                    mem_cs   <= 1'b1;
                end
            end else if (mem_ok) begin
                owner        <= own_idle;
                mem_cs       <= 1'b0;
                mem_bus.done <= owner == own_cpu;
                dbg_done     <= owner == own_dbg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_bus.req) begin
            cpu_addr_h  <= mem_bus.addr[mem_addr_w-1:0];
            cpu_we_h    <= mem_bus.we;
            cpu_wdata_h <= mem_bus.wdata;
        end
        if (dbg_req)
            dbg_addr_h <= dbg_addr;
        if (mem_cs && mem_ok) begin
            if (owner == own_cpu)
                mem_bus.rdata <= mem_rdata;
            else
                dbg_rdata <= mem_rdata;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_cs && !mem_ok) |=> (mem_cs && $stable(mem_addr)));

    // dump master keeps at most one read outstanding
    a_dbg_one: assert property (@(posedge clk) disable iff (rst)
        dbg_req |-> !(dbg_req_q || dbg_pend || owner == own_dbg));

endmodule

/* sim/s16_stim.txt */
# columns: op a b exp1 exp2, all hex. rd/wr: a byte address, b write data, exp1 read data, exp2 berr
# dr: a memory address. both: a cpu address, b memory address, exp1 cpu data, exp2 dump data
# in: a input group, b value. vint: a level, exp1 irq_n. ack: exp1 irq_n. ctl: exp1 {flip,snd_latch}
in 1 c13c8412 0 0
in 2 102030c0 0 0
in 3 65 0 0
in 4 3ca5 0 0
wr 400010 1234 0 0
rd 400010 0 1234 0
wr c70020 beef 0 0
rd c70020 0 beef 0
rd 001234 0 5340 0
rd 800000 0 ffff 1
wr 001000 5555 ffff 1
rd c41000 0 ffda 0
rd c41002 0 ff82 0
rd c41006 0 ff18 0
rd c42000 0 ffa5 0
rd c42002 0 ff3c 0
in 0 2 0 0
rd c41000 0 ff5a 0
rd c41002 0 ff18 0
rd c41002 0 ff81 0
rd c41002 0 ff33 0
rd c41002 0 ffc4 0
rd c41002 0 ff18 0
in 0 1 0 0
rd c41000 0 ff5a 0
rd c41002 0 ffc0 0
rd c41004 0 ff18 0
wr c40000 8077 0 0
ctl 0 0 8077 0
rd c40000 0 ff77 0
rd c41002 0 ffd0 0
rd c41006 0 fff0 0
wr c40000 0033 0 0
ctl 0 0 0033 0
rd c40000 0 7f33 0
vint 1 0 0 0
ack 0 0 1 0
vint 1 0 1 0
vint 0 0 1 0
vint 1 0 0 0
both c70020 20008 beef 1234
dr 12345 0 791f 0

/* sim/tb_clk_gen.sv */
// Testbench clock and reset source.
// clk runs with a 100 ns period; rst is high from time zero
// and drops on the 10th rising edge.
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0; // released on the edge like any driven input
    end
endmodule

/* sim/tb_s16_main_bus.sv */
// Testbench for the main-board bus controller.
// Reads operations and expected values from sim/s16_stim.txt, acts as the
// CPU bus master and the dump master, and models the external memory with
// a random mem_ok delay. Stops at the first mismatch or on a timeout.
`timescale 1ns/1ps

module tb_s16_main_bus;
    import s16_map_pkg::*;

    logic                  clk, rst;
    logic                  cpu_req, cpu_we, cpu_done, cpu_berr;
    logic [cpu_addr_w-1:0] cpu_addr;
    logic [data_w-1:0]     cpu_wdata, cpu_rdata;
    logic                  dbg_req, dbg_done;
    logic [mem_addr_w-1:0] dbg_addr, mem_addr;
    logic [data_w-1:0]     dbg_rdata, mem_wdata, mem_rdata;
    logic                  mem_cs, mem_we, mem_ok;
    logic [1:0]            game_id, coin_input;
    logic [7:0]            joystick1, joystick2, joystick3, joystick4;
    logic [15:0]           joyana1, joyana2;
    logic [3:0]            start_button;
    logic                  service, dip_test, vint, irq_ack;
    logic [7:0]            dipsw_a, dipsw_b, snd_latch;
    logic                  flip, irq_n;

    logic [data_w-1:0] mem_store [logic [mem_addr_w-1:0]]; // sparse memory
    logic [data_w-1:0] got_cpu, got_dbg;
    logic              got_berr;
    int                cpu_at, dbg_at; // cycles from request to done
    int                cycles = 0;
    int                limit = 0;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    s16_main_bus dut_i (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // fixed done latency from the address map, 0 where memory decides
    function automatic int fixed_latency(input logic [23:0] a, input logic we);
        logic rom, ram_like, io;
        rom      = a[23:22] == 2'd0 && !a[18];
        ram_like = (a[22] && a[18:16] == 3'd0) || (a[23:22] == 2'd3 && a[18:16] == 3'd7);
        io       = a[23:22] == 2'd3 && a[18:17] == 2'd2;
        if (rom)
            return we ? 2 : 0;
        if (ram_like)
            return 0;
        return io ? 3 : 2;
    endfunction

    // groups: 0 game, 1 joysticks, 2 analog, 3 buttons, 4 DIP switches
    task automatic set_inputs(input logic [31:0] grp, input logic [31:0] val);
        case (grp)
            0: game_id <= val[1:0];
            1: {joystick4, joystick3, joystick2, joystick1} <= val;
            2: {joyana2, joyana1} <= val;
            3: {dip_test, service, coin_input, start_button} <= val[7:0];
            4: {dipsw_b, dipsw_a} <= val[15:0];
            default: stop_run($sformatf("stim file names unknown input group %0d", grp));
        endcase
        @(posedge clk);
    endtask

    // one CPU cycle, one dump read, or both issued on the same edge
    task automatic issue(input bit use_cpu, input bit use_dbg, input logic [23:0] ca,
                         input bit we, input logic [15:0] wd, input logic [18:0] da);
        bit cpu_seen, dbg_seen;
        int n;
        cpu_seen = !use_cpu;
        dbg_seen = !use_dbg;
        n = 0;
        cpu_req   <= use_cpu;
        cpu_addr  <= ca[23:1];
        cpu_we    <= we;
        cpu_wdata <= wd;
        dbg_req   <= use_dbg;
        dbg_addr  <= da;
        @(posedge clk);
        cpu_req <= 1'b0;
        dbg_req <= 1'b0;
        while (!(cpu_seen && dbg_seen)) begin
            @(posedge clk);
            n++;
            if (!cpu_seen && cpu_done) begin
                cpu_seen = 1'b1;
                cpu_at   = n;
                got_cpu  = cpu_rdata;
                got_berr = cpu_berr;
            end
            if (!dbg_seen && dbg_done) begin
                dbg_seen = 1'b1;
                dbg_at   = n;
                got_dbg  = dbg_rdata;
            end
        end
    endtask

    // external memory, mem_ok after 0 to 5 wait cycles
    initial begin : mem_model
        int wait_cnt;
        mem_ok    = 1'b0;
        mem_rdata = '0;
        void'($urandom(32'he036));
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            mem_ok <= 1'b0;
            if (mem_cs && !mem_ok) begin
                if (wait_cnt == 0) begin
                    if (mem_we)
                        mem_store[mem_addr] = mem_wdata;
                    mem_ok    <= 1'b1;
                    mem_rdata <= mem_store.exists(mem_addr) ? mem_store[mem_addr]
                                                            : mem_addr[15:0] ^ 16'h5a5a;
                end else begin
                    wait_cnt--;
                end
            end else begin
                wait_cnt = $urandom % 6;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit)
            stop_run($sformatf("run timed out after %0d cycles", limit));
    end

    initial begin : main
        int          fd, lat;
        string       op, line;
        logic [31:0] a, b, e1, e2;
        string       op_q[$];
        logic [31:0] a_q[$], b_q[$], e1_q[$], e2_q[$];

        {cpu_req, cpu_addr, cpu_we, cpu_wdata, dbg_req, dbg_addr} = '0;
        {game_id, joystick1, joystick2, joystick3, joystick4, joyana1, joyana2} = '0;
        {start_button, coin_input, service, dip_test, dipsw_a, dipsw_b} = '0;
        vint    = 1'b0;
        irq_ack = 1'b0;

        fd = $fopen("sim/s16_stim.txt", "r");
        if (fd == 0)
            stop_run("cannot open the stimulus file sim/s16_stim.txt");
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op.substr(0, 0) == "#") begin
                void'($fgets(line, fd)); // rest of a comment line
            end else if ($fscanf(fd, "%h %h %h %h", a, b, e1, e2) == 4) begin
                op_q.push_back(op);
                a_q.push_back(a);
                b_q.push_back(b);
                e1_q.push_back(e1);
                e2_q.push_back(e2);
            end else begin
                stop_run({"stim file has a malformed line for operation ", op});
            end
        end
        $fclose(fd);
        limit = op_q.size() * 20;

        @(negedge rst);
        @(posedge clk);
        check({cpu_done, cpu_berr, mem_cs, dbg_done, irq_n, flip, snd_latch},
              {5'b00001, 1'b0, 8'h00}, "outputs after reset");

        for (int i = 0; i < op_q.size(); i++) begin
            a  = a_q[i];
            b  = b_q[i];
            e1 = e1_q[i];
            e2 = e2_q[i];
            case (op_q[i])
                "in": set_inputs(a, b);
                "rd", "wr": begin
                    issue(1'b1, 1'b0, a[23:0], op_q[i] == "wr", b[15:0], '0);
                    check(got_berr, e2, $sformatf("%s %h bus error", op_q[i], a));
                    if (op_q[i] == "rd" || e2[0])
                        check(got_cpu, e1, $sformatf("%s %h data", op_q[i], a));
                    lat = fixed_latency(a[23:0], op_q[i] == "wr");
                    if (lat != 0)
                        check(cpu_at, lat, $sformatf("%s %h done latency", op_q[i], a));
                end
                "dr": begin
                    issue(1'b0, 1'b1, '0, 1'b0, '0, a[18:0]);
                    check(got_dbg, e1, $sformatf("dump read %h data", a));
                end
                "both": begin
                    issue(1'b1, 1'b1, a[23:0], 1'b0, '0, b[18:0]);
                    check(got_cpu, e1, $sformatf("shared cpu read %h data", a));
                    check(got_dbg, e2, $sformatf("shared dump read %h data", b));
                    check(cpu_at <= dbg_at, 1, "cpu done no later than dump done");
                end
                "vint": begin
                    vint <= a[0];
                    repeat (2) @(posedge clk);
                    check(irq_n, e1, $sformatf("irq_n after vint level %0d", a[0]));
                end
                "ack": begin
                    irq_ack <= 1'b1;
                    @(posedge clk);
                    irq_ack <= 1'b0;
                    @(posedge clk);
                    check(irq_n, e1, "irq_n after acknowledge");
                end
                "ctl": check({flip, 7'h00, snd_latch}, e1, "flip and sound latch outputs");
                default: stop_run({"stim file has unknown operation ", op_q[i]});
            endcase
        end

        $display("Simulation completed successfully");
        $finish;
    end
endmodule
